// File: hdl/copper_pkg.sv
package copper_pkg;

    // Copper program memory is 2K 32-bit words
    localparam int COPP_W = 11;

    // Basic data types
    typedef logic [COPP_W-1:0] pc_t;
    typedef logic [15:0]       word_t;
    typedef logic [15:0]       addr_t;
    typedef logic [31:0]       insn_word_t;
    typedef logic [10:0]       hres_t;
    typedef logic [10:0]       vres_t;

    // Raster totals for 640x480 timing
    localparam int TOTAL_WIDTH  = 800;
    localparam int TOTAL_HEIGHT = 525;

    // Restart point is this many pixels before the end of the last line,
    // so the first instruction is fetched before the frame begins
    localparam int RESTART_H_OFFSET = 4;

    // XR memory regions reachable by MOVE
    localparam addr_t XR_COLOR_MEM  = 16'h8000;
    localparam addr_t XR_TILE_MEM   = 16'hA000;
    localparam addr_t XR_COPPER_MEM = 16'hC000;

    // Control register layout
    // Bit 15 enables the copper, low bits hold the initial PC
    localparam int CTRL_EN_BIT = 15;

    // Opcode sits in the top three bits of the instruction
    typedef enum logic [2:0] {
        OP_WAIT  = 3'd0,
        OP_SKIP  = 3'd1,
        OP_JMP   = 3'd2,
        OP_MOVER = 3'd3,
        OP_MOVEF = 3'd4,
        OP_MOVEP = 3'd5,
        OP_MOVEC = 3'd6,
        OP_RSVD  = 3'd7
    } opcode_t;

    // Fetch side FSM
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_FETCH,
        SEQ_LATCH,
        SEQ_ISSUE
    } seq_state_t;

    // Execute side FSM
    typedef enum logic [1:0] {
        EX_IDLE,
        EX_COMPARE,
        EX_EXEC
    } exec_state_t;

endpackage

// File: hdl/copper_exec_if.sv
`timescale 1ns/1ps

interface copper_exec_if
    import copper_pkg::*;
();

    // Instruction handed from the sequencer
    // Held stable from insn_valid rising until done
    logic       insn_valid;
    insn_word_t insn;

    // One-cycle completion pulse from the executor
    logic       done;

    // Branch result, only meaningful while done is high
    logic       take_jump;
    logic       take_skip;
    pc_t        jump_pc;

    // Fetch side
    modport seq (
        output insn_valid,
        output insn,
        input  done,
        input  take_jump,
        input  take_skip,
        input  jump_pc
    );

    // Execute side
    modport exec (
        input  insn_valid,
        input  insn,
        output done,
        output take_jump,
        output take_skip,
        output jump_pc
    );

endinterface

// File: hdl/copper_sequencer.sv
`timescale 1ns/1ps

module copper_sequencer
    import copper_pkg::*;
(
    input  logic       clk,
    input  logic       copp_reset,
    input  logic       copp_reg_wr_i,
    input  word_t      copp_reg_data_i,
    input  hres_t      h_count_i,
    input  vres_t      v_count_i,
    output logic       coppermem_rd_en_o,
    output pc_t        coppermem_rd_addr_o,
    input  insn_word_t coppermem_rd_data_i,
    output logic       frame_restart_o,
    copper_exec_if.seq ex
);

    // Control register
    logic       ctrl_en;
    pc_t        ctrl_init_pc;

    // Fields of an incoming control write
    logic       reg_en_bit;
    pc_t        reg_init_pc;

    // Fetch state
    seq_state_t seq_state;
    pc_t        pc;
    insn_word_t insn_q;
    logic       insn_valid_q;

    assign reg_en_bit  = copp_reg_data_i[CTRL_EN_BIT];
    assign reg_init_pc = copp_reg_data_i[COPP_W-1:0];

    // Restart point on the last line of the frame
    assign frame_restart_o = (h_count_i == hres_t'(TOTAL_WIDTH - RESTART_H_OFFSET)) &&
                             (v_count_i == vres_t'(TOTAL_HEIGHT - 1));

    // Read strobe only in the single fetch cycle
    // Address is the current PC, it moves on at the end of that cycle
    assign coppermem_rd_en_o   = (seq_state == SEQ_FETCH) && ctrl_en;
    assign coppermem_rd_addr_o = pc;

    // Instruction towards the executor
    assign ex.insn_valid = insn_valid_q;
    assign ex.insn       = insn_q;

    // Control register write
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            ctrl_en      <= 1'b0;
            ctrl_init_pc <= '0;
        end else if (copp_reg_wr_i) begin
            ctrl_en      <= reg_en_bit;
            ctrl_init_pc <= reg_init_pc;
        end
    end

    // Fetch FSM and program counter
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            seq_state    <= SEQ_IDLE;
            pc           <= '0;
            insn_valid_q <= 1'b0;
        end else if (frame_restart_o) begin
            // New frame, start over at the initial PC
            seq_state    <= SEQ_IDLE;
            pc           <= ctrl_init_pc;
            insn_valid_q <= 1'b0;
        end else begin
            case (seq_state)
                SEQ_IDLE: begin
                    // Enabling a stopped copper also loads its start address
                    if (copp_reg_wr_i && reg_en_bit && !ctrl_en) begin
                        pc <= reg_init_pc;
                    end
                    if (ctrl_en) begin
                        seq_state <= SEQ_FETCH;
                    end
                end
                SEQ_FETCH: begin
                    if (ctrl_en) begin
                        // Point at the next word while the read is in flight
                        pc        <= pc + 1'b1;
                        seq_state <= SEQ_LATCH;
                    end else begin
                        seq_state <= SEQ_IDLE;
                    end
                end
                SEQ_LATCH: begin
                    // Read data is present on this edge
                    insn_valid_q <= 1'b1;
                    seq_state    <= SEQ_ISSUE;
                end
                SEQ_ISSUE: begin
                    // Hold the instruction until the executor finishes it
                    if (ex.done) begin
                        insn_valid_q <= 1'b0;
                        if (ex.take_jump) begin
                            pc <= ex.jump_pc;
                        end else if (ex.take_skip) begin
                            // PC already points past this one, step once more
                            pc <= pc + 1'b1;
                        end
                        seq_state <= SEQ_FETCH;
                    end
                end
                default: begin
                    seq_state <= SEQ_IDLE;
                end
            endcase
        end
    end

    // Instruction register
    always_ff @(posedge clk) begin
        if (seq_state == SEQ_LATCH) begin
            insn_q <= coppermem_rd_data_i;
        end
    end

endmodule

// File: hdl/copper_exec.sv
`timescale 1ns/1ps

module copper_exec
    import copper_pkg::*;
(
    input  logic        clk,
    input  logic        copp_reset,
    input  logic        frame_restart_i,
    input  hres_t       h_count_i,
    input  vres_t       v_count_i,
    output logic        xr_wr_en_o,
    output addr_t       xr_wr_addr_o,
    output word_t       xr_wr_data_o,
    input  logic        xr_wr_ack_i,
    copper_exec_if.exec ex
);

    exec_state_t ex_state;

    // Decoded fields
    opcode_t     opcode;
    logic        ignore_v;
    logic        ignore_h;
    vres_t       v_pos;
    hres_t       h_pos;
    word_t       move_data;
    logic [7:0]  move_r_off;
    logic [12:0] move_f_off;
    logic [8:0]  move_p_off;
    pc_t         move_c_off;
    addr_t       move_addr;

    // Registered beam comparisons
    logic        v_reached;
    logic        h_reached;

    // Decisions
    logic        pos_met;
    logic        wait_met;
    logic        is_move;
    logic        step_ok;
    logic        ex_done;
    logic        wr_launch;

    // XR write port registers
    logic        wr_en_q;
    addr_t       wr_addr_q;
    word_t       wr_data_q;

    // Field extraction, the sequencer keeps the instruction stable
    assign opcode     = opcode_t'(ex.insn[31:29]);
    assign ignore_v   = ex.insn[0];
    assign ignore_h   = ex.insn[1];
    assign v_pos      = ex.insn[26:16];
    assign h_pos      = ex.insn[14:4];
    assign move_data  = ex.insn[15:0];
    assign move_r_off = ex.insn[23:16];
    assign move_f_off = ex.insn[28:16];
    assign move_p_off = ex.insn[24:16];
    assign move_c_off = ex.insn[26:16];

    // XR address by MOVE flavour
    always_comb begin
        case (opcode)
            OP_MOVEF: move_addr = {XR_TILE_MEM[15:13], move_f_off};
            OP_MOVEP: move_addr = {XR_COLOR_MEM[15:9], move_p_off};
            OP_MOVEC: move_addr = {XR_COPPER_MEM[15:COPP_W], move_c_off};
            // Register space, upper byte zero
            default:  move_addr = {8'h00, move_r_off};
        endcase
    end

    assign is_move = (opcode == OP_MOVER) || (opcode == OP_MOVEF) ||
                     (opcode == OP_MOVEP) || (opcode == OP_MOVEC);

    // Position test with ignore flags
    assign pos_met  = (ignore_v || v_reached) && (ignore_h || h_reached);
    // Both flags set means wait for the rest of the frame
    assign wait_met = pos_met && !(ignore_v && ignore_h);

    // Can the instruction in EX_EXEC finish this cycle
    always_comb begin
        case (opcode)
            OP_WAIT:  step_ok = wait_met;
            OP_MOVER,
            OP_MOVEF,
            OP_MOVEP,
            OP_MOVEC: step_ok = !wr_en_q || xr_wr_ack_i;  // previous write leaves on this edge
            default:  step_ok = 1'b1;
        endcase
    end

    // Restart abandons the instruction, nothing completes or gets written
    assign ex_done   = (ex_state == EX_EXEC) && step_ok && !frame_restart_i;
    assign wr_launch = ex_done && is_move;

    // Results back to the sequencer
    assign ex.done      = ex_done;
    assign ex.take_jump = (opcode == OP_JMP);
    assign ex.take_skip = (opcode == OP_SKIP) && pos_met;
    assign ex.jump_pc   = ex.insn[27:17];

    // Execute FSM
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            ex_state <= EX_IDLE;
        end else if (frame_restart_i) begin
            ex_state <= EX_IDLE;
        end else begin
            case (ex_state)
                EX_IDLE: begin
                    if (ex.insn_valid) begin
                        ex_state <= EX_COMPARE;
                    end
                end
                EX_COMPARE: begin
                    ex_state <= EX_EXEC;
                end
                EX_EXEC: begin
                    if (ex_done) begin
                        ex_state <= EX_IDLE;
                    end else if (opcode == OP_WAIT) begin
                        // Unmet WAIT samples the beam again
                        ex_state <= EX_COMPARE;
                    end
                    // MOVE with a pending write stays here
                end
                default: begin
                    ex_state <= EX_IDLE;
                end
            endcase
        end
    end

    // Beam comparisons, sampled once per compare cycle
    always_ff @(posedge clk) begin
        if (ex_state == EX_COMPARE) begin
            v_reached <= (v_count_i >= v_pos);
            h_reached <= (h_count_i >= h_pos);
        end
    end

    // Write request stays up until acknowledged
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            wr_en_q <= 1'b0;
        end else if (wr_launch) begin
            wr_en_q <= 1'b1;
        end else if (xr_wr_ack_i) begin
            wr_en_q <= 1'b0;
        end
    end

    // Address and data only change when a new write starts
    always_ff @(posedge clk) begin
        if (wr_launch) begin
            wr_addr_q <= move_addr;
            wr_data_q <= move_data;
        end
    end

    assign xr_wr_en_o   = wr_en_q;
    assign xr_wr_addr_o = wr_addr_q;
    assign xr_wr_data_o = wr_data_q;

endmodule

// File: hdl/copper_top.sv
`timescale 1ns/1ps

module copper_top
    import copper_pkg::*;
(
    input  logic       clk,
    input  logic       copp_reset,

    // Control register strobe
    input  logic       copp_reg_wr_i,
    input  word_t      copp_reg_data_i,

    // Beam position
    input  hres_t      h_count_i,
    input  vres_t      v_count_i,

    // Program memory read, fixed latency
    output logic       coppermem_rd_en_o,
    output pc_t        coppermem_rd_addr_o,
    input  insn_word_t coppermem_rd_data_i,

    // XR write with ack handshake
    output logic       xr_wr_en_o,
    output addr_t      xr_wr_addr_o,
    output word_t      xr_wr_data_o,
    input  logic       xr_wr_ack_i
);

    // Frame restart from the sequencer to the executor
    logic frame_restart;

    // Instruction handshake between the two halves
    copper_exec_if ex_if ();

    copper_sequencer u_seq (
        .clk                 (clk),
        .copp_reset          (copp_reset),
        .copp_reg_wr_i       (copp_reg_wr_i),
        .copp_reg_data_i     (copp_reg_data_i),
        .h_count_i           (h_count_i),
        .v_count_i           (v_count_i),
        .coppermem_rd_en_o   (coppermem_rd_en_o),
        .coppermem_rd_addr_o (coppermem_rd_addr_o),
        .coppermem_rd_data_i (coppermem_rd_data_i),
        .frame_restart_o     (frame_restart),
        .ex                  (ex_if.seq)
    );

    copper_exec u_exec (
        .clk             (clk),
        .copp_reset      (copp_reset),
        .frame_restart_i (frame_restart),
        .h_count_i       (h_count_i),
        .v_count_i       (v_count_i),
        .xr_wr_en_o      (xr_wr_en_o),
        .xr_wr_addr_o    (xr_wr_addr_o),
        .xr_wr_data_o    (xr_wr_data_o),
        .xr_wr_ack_i     (xr_wr_ack_i),
        .ex              (ex_if.exec)
    );

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk_o
);

    // 40 ns period, roughly the 25 MHz pixel clock
    localparam time HALF_PERIOD = 20ns;

    initial begin
        clk_o = 1'b0;
    end

    always begin
        #(HALF_PERIOD) clk_o = ~clk_o;
    end

endmodule

// File: tests/copper_checker.sv
`timescale 1ns/1ps

module copper_checker (
    input logic        clk,
    input logic        copp_reset,
    input logic        rd_en_i,
    input logic        wr_en_i,
    input logic [15:0] wr_addr_i,
    input logic [15:0] wr_data_i,
    input logic        wr_ack_i
);

    // Number of failed assertions
    int assert_fails = 0;

    // Pending XR write keeps enable, address and data until ack
    property p_wr_hold;
        @(posedge clk) disable iff (copp_reset)
        (wr_en_i && !wr_ack_i) |=> (wr_en_i && $stable(wr_addr_i) && $stable(wr_data_i));
    endproperty

    // Program memory strobe is a single-cycle pulse
    property p_rd_pulse;
        @(posedge clk) disable iff (copp_reset)
        rd_en_i |=> !rd_en_i;
    endproperty

    // Nothing leaves the copper right after a reset edge
    property p_reset_quiet;
        @(posedge clk) copp_reset |=> (!rd_en_i && !wr_en_i);
    endproperty

    a_wr_hold: assert property (p_wr_hold)
        else begin
            assert_fails++;
            $error("XR write request changed or dropped before ack");
        end

    a_rd_pulse: assert property (p_rd_pulse)
        else begin
            assert_fails++;
            $error("Program memory read strobe held for more than one cycle");
        end

    a_reset_quiet: assert property (p_reset_quiet)
        else begin
            assert_fails++;
            $error("Output strobe high in the cycle after reset");
        end

endmodule

// File: tests/copper_tb.sv
`timescale 1ns/1ps

module copper_tb;

    // Table size
    localparam int N_TESTS    = 7;
    localparam int MAX_WORDS  = 10;
    localparam int MAX_WRITES = 6;

    // Beam change after the first writes of a row
    localparam int PH_NONE    = 0;
    localparam int PH_RAISE   = 1;
    localparam int PH_RESTART = 2;

    // Instruction opcodes, top three bits
    localparam logic [2:0] OPC_WAIT  = 3'd0;
    localparam logic [2:0] OPC_SKIP  = 3'd1;
    localparam logic [2:0] OPC_JMP   = 3'd2;
    localparam logic [2:0] OPC_MOVER = 3'd3;
    localparam logic [2:0] OPC_MOVEF = 3'd4;
    localparam logic [2:0] OPC_MOVEP = 3'd5;
    localparam logic [2:0] OPC_MOVEC = 3'd6;
    localparam logic [2:0] OPC_RSVD  = 3'd7;

    // Restart point, 4 pixels before the end of line 524 of 800x525
    localparam logic [10:0] RESTART_H = 11'd796;
    localparam logic [10:0] RESTART_V = 11'd524;

    localparam int MAX_ACK_DELAY = 12;
    localparam int ACK_TABLE     = 64;
    localparam int QUIET_CYCLES  = 40;

    logic        clk;
    logic        copp_reset = 1'b1;
    logic        reg_wr     = 1'b0;
    logic [15:0] reg_data   = '0;
    logic [10:0] h_count    = '0;
    logic [10:0] v_count    = '0;
    logic        rd_en;
    logic [10:0] rd_addr;
    logic [31:0] rd_data    = '0;
    logic        wr_en;
    logic [15:0] wr_addr;
    logic [15:0] wr_data;
    logic        wr_ack     = 1'b0;

    // Program memory model
    logic [31:0] prog_mem [2048];

    // Stimulus table, one row per test
    string       t_name    [N_TESTS];
    logic [10:0] t_init_pc [N_TESTS];
    int          t_len     [N_TESTS];
    logic [31:0] t_prog    [N_TESTS][MAX_WORDS];
    logic [10:0] t_h0      [N_TESTS];
    logic [10:0] t_v0      [N_TESTS];
    int          t_phase   [N_TESTS];
    logic [10:0] t_h1      [N_TESTS];
    logic [10:0] t_v1      [N_TESTS];
    int          t_n_pre   [N_TESTS];
    int          t_n_exp   [N_TESTS];
    logic [31:0] t_exp     [N_TESTS][MAX_WRITES];
    bit          t_rand    [N_TESTS];

    // Random ack stalls, drawn once after seeding
    int          ack_delays [ACK_TABLE];
    int          ack_idx       = 0;

    // Run state
    logic [31:0] write_q [$];
    bit          rand_ack      = 1'b0;
    int          ack_delay     = 0;
    int          errors        = 0;
    int          checks        = 0;
    int          cycle_count   = 0;
    int          timeout_limit = 0;

    tb_clock u_clock (
        .clk_o (clk)
    );

    copper_top UUT (
        .clk                 (clk),
        .copp_reset          (copp_reset),
        .copp_reg_wr_i       (reg_wr),
        .copp_reg_data_i     (reg_data),
        .h_count_i           (h_count),
        .v_count_i           (v_count),
        .coppermem_rd_en_o   (rd_en),
        .coppermem_rd_addr_o (rd_addr),
        .coppermem_rd_data_i (rd_data),
        .xr_wr_en_o          (wr_en),
        .xr_wr_addr_o        (wr_addr),
        .xr_wr_data_o        (wr_data),
        .xr_wr_ack_i         (wr_ack)
    );

    bind copper_top copper_checker u_checker (
        .clk        (clk),
        .copp_reset (copp_reset),
        .rd_en_i    (coppermem_rd_en_o),
        .wr_en_i    (xr_wr_en_o),
        .wr_addr_i  (xr_wr_addr_o),
        .wr_data_i  (xr_wr_data_o),
        .wr_ack_i   (xr_wr_ack_i)
    );

    // WAIT or SKIP word
    function automatic logic [31:0] beam_insn(input logic [2:0] op, input logic [10:0] v,
                                              input logic [10:0] h, input logic ign_v,
                                              input logic ign_h);
        return {op, 2'b00, v, 1'b0, h, 2'b00, ign_h, ign_v};
    endfunction

    // MOVE word, offset zero extended into bits 28:16
    function automatic logic [31:0] move_insn(input logic [2:0] op, input logic [12:0] off,
                                              input logic [15:0] data);
        return {op, off, data};
    endfunction

    function automatic logic [31:0] jump_insn(input logic [10:0] target);
        return {OPC_JMP, 1'b0, target, 17'h0};
    endfunction

    // Zero in fixed mode, otherwise the next stall from the random table
    function automatic int pick_ack_delay();
        if (rand_ack) begin
            return ack_delays[ack_idx % ACK_TABLE];
        end
        return 0;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic set_row(input int row, input string name, input logic [10:0] init_pc,
                           input logic [10:0] h0, input logic [10:0] v0, input int phase,
                           input logic [10:0] h1, input logic [10:0] v1, input int n_pre,
                           input bit rnd);
        t_name[row]    = name;
        t_init_pc[row] = init_pc;
        t_h0[row]      = h0;
        t_v0[row]      = v0;
        t_phase[row]   = phase;
        t_h1[row]      = h1;
        t_v1[row]      = v1;
        t_n_pre[row]   = n_pre;
        t_rand[row]    = rnd;
        t_len[row]     = 0;
        t_n_exp[row]   = 0;
    endtask

    task automatic add_word(input int row, input logic [31:0] word);
        t_prog[row][t_len[row]] = word;
        t_len[row]++;
    endtask

    // Expected XR write, address in the upper half
    task automatic add_write(input int row, input logic [15:0] addr, input logic [15:0] data);
        t_exp[row][t_n_exp[row]] = {addr, data};
        t_n_exp[row]++;
    endtask

    task automatic build_table();
        logic [31:0] stop;
        stop = beam_insn(OPC_WAIT, 11'd0, 11'd0, 1'b1, 1'b1);
        // Each MOVE flavour once
        set_row(0, "moves", 11'h000, 11'd0, 11'd0, PH_NONE, 11'd0, 11'd0, 4, 1'b0);
        add_word(0, move_insn(OPC_MOVER, 13'h0012, 16'h1111));
        add_word(0, move_insn(OPC_MOVEF, 13'h1abc, 16'h2222));
        add_word(0, move_insn(OPC_MOVEP, 13'h01f3, 16'h3333));
        add_word(0, move_insn(OPC_MOVEC, 13'h07ff, 16'h4444));
        add_word(0, stop);
        add_write(0, 16'h0012, 16'h1111);
        add_write(0, 16'hbabc, 16'h2222);
        add_write(0, 16'h81f3, 16'h3333);
        add_write(0, 16'hc7ff, 16'h4444);
        // WAIT holds until the beam is moved to its target
        set_row(1, "wait_block", 11'h000, 11'd0, 11'd10, PH_RAISE, 11'd200, 11'd100, 1, 1'b0);
        add_word(1, move_insn(OPC_MOVER, 13'h0001, 16'haaaa));
        add_word(1, beam_insn(OPC_WAIT, 11'd100, 11'd200, 1'b0, 1'b0));
        add_word(1, move_insn(OPC_MOVER, 13'h0002, 16'hbbbb));
        add_word(1, stop);
        add_write(1, 16'h0001, 16'haaaa);
        add_write(1, 16'h0002, 16'hbbbb);
        // Already reached, second one ignores vertical
        set_row(2, "wait_reached", 11'h000, 11'd300, 11'd50, PH_NONE, 11'd0, 11'd0, 2, 1'b0);
        add_word(2, move_insn(OPC_MOVER, 13'h0003, 16'h0303));
        add_word(2, beam_insn(OPC_WAIT, 11'd40, 11'd250, 1'b0, 1'b0));
        add_word(2, beam_insn(OPC_WAIT, 11'd500, 11'd100, 1'b1, 1'b0));
        add_word(2, move_insn(OPC_MOVER, 13'h0004, 16'h0404));
        add_word(2, stop);
        add_write(2, 16'h0003, 16'h0303);
        add_write(2, 16'h0004, 16'h0404);
        // Both ignore flags, never passes even late in the frame
        set_row(3, "wait_forever", 11'h000, 11'd0, 11'd0, PH_RAISE, 11'd790, 11'd520, 1, 1'b0);
        add_word(3, move_insn(OPC_MOVER, 13'h0005, 16'h0505));
        add_word(3, stop);
        add_word(3, move_insn(OPC_MOVER, 13'h0006, 16'h0606));
        add_write(3, 16'h0005, 16'h0505);
        // SKIP met, SKIP unmet, JMP over two words onto a reserved no-op
        set_row(4, "skip_jmp", 11'h100, 11'd100, 11'd100, PH_NONE, 11'd0, 11'd0, 2, 1'b0);
        add_word(4, beam_insn(OPC_SKIP, 11'd50, 11'd50, 1'b0, 1'b0));
        add_word(4, move_insn(OPC_MOVER, 13'h0007, 16'h0707));
        add_word(4, beam_insn(OPC_SKIP, 11'd200, 11'd50, 1'b0, 1'b0));
        add_word(4, move_insn(OPC_MOVER, 13'h0008, 16'h0808));
        add_word(4, jump_insn(11'h107));
        add_word(4, move_insn(OPC_MOVER, 13'h0009, 16'h0909));
        add_word(4, move_insn(OPC_MOVER, 13'h000a, 16'h0a0a));
        add_word(4, {OPC_RSVD, 29'h0000_1234});
        add_word(4, move_insn(OPC_MOVEC, 13'h0010, 16'h1010));
        add_word(4, stop);
        add_write(4, 16'h0008, 16'h0808);
        add_write(4, 16'hc010, 16'h1010);
        // Frame restart runs the program again from the initial PC
        set_row(5, "restart", 11'h020, 11'd0, 11'd0, PH_RESTART, 11'd0, 11'd0, 2, 1'b0);
        add_word(5, move_insn(OPC_MOVER, 13'h000b, 16'h0b0b));
        add_word(5, move_insn(OPC_MOVEP, 13'h0010, 16'hc0de));
        add_word(5, stop);
        add_write(5, 16'h000b, 16'h0b0b);
        add_write(5, 16'h8010, 16'hc0de);
        add_write(5, 16'h000b, 16'h0b0b);
        add_write(5, 16'h8010, 16'hc0de);
        // Back to back MOVEs under random ack stalls
        set_row(6, "rand_ack", 11'h000, 11'd0, 11'd0, PH_NONE, 11'd0, 11'd0, 6, 1'b1);
        add_word(6, move_insn(OPC_MOVER, 13'h0010, 16'h1234));
        add_word(6, move_insn(OPC_MOVEF, 13'h0000, 16'h5678));
        add_word(6, move_insn(OPC_MOVEP, 13'h01ff, 16'h9abc));
        add_word(6, move_insn(OPC_MOVEC, 13'h0000, 16'hdef0));
        add_word(6, move_insn(OPC_MOVER, 13'h00ff, 16'hffff));
        add_word(6, move_insn(OPC_MOVEF, 13'h1fff, 16'h0001));
        add_word(6, stop);
        add_write(6, 16'h0010, 16'h1234);
        add_write(6, 16'ha000, 16'h5678);
        add_write(6, 16'h81ff, 16'h9abc);
        add_write(6, 16'hc000, 16'hdef0);
        add_write(6, 16'h00ff, 16'hffff);
        add_write(6, 16'hbfff, 16'h0001);
    endtask

    // Read data valid by the second edge after the strobe
    // Reserved opcode outside that window, so a late sample shows up as a lost write
    always @(posedge clk) begin
        if (rd_en) begin
            rd_data <= prog_mem[rd_addr];
        end else begin
            rd_data <= 32'hffff_ffff;
        end
    end

    // XR ack after a per-write delay, dropped once the transfer completes
    always @(posedge clk) begin
        if (copp_reset) begin
            wr_ack    <= 1'b0;
            ack_delay <= pick_ack_delay();
            ack_idx   <= ack_idx + 1;
        end else if (wr_ack) begin
            wr_ack    <= 1'b0;
            ack_delay <= pick_ack_delay();
            ack_idx   <= ack_idx + 1;
        end else if (wr_en) begin
            if (ack_delay == 0) begin
                wr_ack <= 1'b1;
            end else begin
                ack_delay <= ack_delay - 1;
            end
        end
    end

    // Completed XR writes in order
    always @(posedge clk) begin
        if (wr_en && wr_ack) begin
            write_q.push_back({wr_addr, wr_data});
        end
    end

    // Watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            $display("Timeout after %0d cycles, expected XR writes never arrived", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    task automatic reset_dut();
        @(posedge clk);
        copp_reset <= 1'b1;
        repeat (10) @(posedge clk);
        copp_reset <= 1'b0;
        write_q.delete();
    endtask

    // Fill pattern is a reserved word tagged with its own address
    task automatic load_program(input int row);
        int a;
        for (a = 0; a < 2048; a++) begin
            prog_mem[a] = {OPC_RSVD, 2'b00, 11'(a), 16'h0000};
        end
        for (a = 0; a < t_len[row]; a++) begin
            prog_mem[11'(t_init_pc[row] + a)] = t_prog[row][a];
        end
    endtask

    task automatic enable_copper(input logic [10:0] init_pc);
        @(posedge clk);
        reg_wr   <= 1'b1;
        reg_data <= {1'b1, 4'b0000, init_pc};
        @(posedge clk);
        reg_wr   <= 1'b0;
    endtask

    task automatic wait_writes(input int n);
        while (write_q.size() < n) begin
            @(negedge clk);
        end
    endtask

    task automatic settle();
        repeat (QUIET_CYCLES) @(negedge clk);
    endtask

    // Enable bit clear, so nothing is fetched or written
    task automatic check_idle();
        bit seen;
        seen = 1'b0;
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            if (rd_en || wr_en) begin
                seen = 1'b1;
            end
        end
        check_value("idle after reset", 32'd0, 32'(seen));
    endtask

    task automatic run_test(input int row);
        int i;
        rand_ack = t_rand[row];
        @(posedge clk);
        h_count <= t_h0[row];
        v_count <= t_v0[row];
        reset_dut();
        load_program(row);
        enable_copper(t_init_pc[row]);
        wait_writes(t_n_pre[row]);
        settle();
        check_value($sformatf("%s writes before beam change", t_name[row]),
                    t_n_pre[row], write_q.size());
        if (t_phase[row] == PH_RAISE) begin
            @(posedge clk);
            h_count <= t_h1[row];
            v_count <= t_v1[row];
        end else if (t_phase[row] == PH_RESTART) begin
            // Restart position for exactly one cycle
            @(posedge clk);
            h_count <= RESTART_H;
            v_count <= RESTART_V;
            @(posedge clk);
            h_count <= t_h0[row];
            v_count <= t_v0[row];
        end
        if (t_phase[row] != PH_NONE) begin
            wait_writes(t_n_exp[row]);
            settle();
            check_value($sformatf("%s writes in total", t_name[row]),
                        t_n_exp[row], write_q.size());
        end
        for (i = 0; i < t_n_exp[row]; i++) begin
            check_value($sformatf("%s write %0d", t_name[row], i), t_exp[row][i], write_q[i]);
        end
    endtask

    initial begin
        int row;
        int total_len;
        int k;
        void'($urandom(32'had33));
        for (k = 0; k < ACK_TABLE; k++) begin
            ack_delays[k] = int'($urandom % (MAX_ACK_DELAY + 1));
        end
        build_table();
        total_len = 0;
        for (row = 0; row < N_TESTS; row++) begin
            total_len += t_len[row];
        end
        timeout_limit = total_len * 5 * MAX_ACK_DELAY + 2000;
        reset_dut();
        check_idle();
        for (row = 0; row < N_TESTS; row++) begin
            run_test(row);
        end
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, UUT.u_checker.assert_fails);
        if (errors == 0 && UUT.u_checker.assert_fails == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: copper_top.f
hdl/copper_pkg.sv
hdl/copper_exec_if.sv
hdl/copper_sequencer.sv
hdl/copper_exec.sv
hdl/copper_top.sv
tests/tb_clock.sv
tests/copper_checker.sv
tests/copper_tb.sv
